//--- verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // Widths of the fetch path and the memory bus
    localparam int ADDR_W      = 32;
    localparam int INST_W      = 32;
    localparam int LINE_W      = 2 * INST_W;
    localparam int LINE_ADDR_W = ADDR_W - 3;
    localparam int MEM_TAG_W   = 4;

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [INST_W-1:0]      inst_t;
    typedef logic [LINE_W-1:0]      line_data_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // Zero tag means no transaction or a rejected load
    typedef logic [MEM_TAG_W-1:0]   mem_tag_t;

    typedef logic [1:0]             mem_command_t;

    // Bus commands
    localparam mem_command_t BUS_NONE = 2'd0;
    localparam mem_command_t BUS_LOAD = 2'd1;

endpackage

`default_nettype wire

//--- verilog/fetch_request_gen.sv
`default_nettype none

module fetch_request_gen #(
    parameter int N_WAY      = 2,
    parameter int N_PREFETCH = 2
) (
    input  logic                                     enable,
    input  icache_pkg::addr_t                        fetch_addr,
    input  logic [$clog2(N_WAY):0]                   fetch_count,
    output icache_pkg::addr_t      [N_WAY-1:0]       slot_addr,
    output logic                   [N_WAY-1:0]       slot_valid,
    output icache_pkg::line_addr_t [N_PREFETCH-1:0]  pf_line,
    output logic                   [N_PREFETCH-1:0]  pf_valid
);

    localparam int CNT_W = $clog2(N_WAY) + 1;

    icache_pkg::addr_t      last_addr;
    icache_pkg::line_addr_t base_line;

    // Slot i fetches the word 4*i bytes past the program counter
    always_comb begin
        for (int i = 0; i < N_WAY; i++) begin
            slot_addr[i]  = fetch_addr + icache_pkg::addr_t'(4 * i);
            slot_valid[i] = enable && (CNT_W'(i) < fetch_count);
        end
    end

    // Address of the last requested instruction, or the PC itself for an empty request
    always_comb begin
        if (fetch_count == '0) begin
            last_addr = fetch_addr;
        end else begin
            last_addr = fetch_addr + (icache_pkg::addr_t'(fetch_count - 1'b1) << 2);
        end
    end

    assign base_line = last_addr[icache_pkg::ADDR_W-1:3];

    // Sequential lines after the last one touched
    always_comb begin
        for (int j = 0; j < N_PREFETCH; j++) begin
            pf_line[j]  = base_line + icache_pkg::line_addr_t'(j + 1);
            pf_valid[j] = enable;
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_array.sv
`default_nettype none

module icache_array #(
    parameter int N_WAY       = 2,
    parameter int N_PREFETCH  = 2,
    parameter int CACHE_LINES = 32
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  icache_pkg::addr_t      [N_WAY-1:0]       slot_addr,
    input  logic                   [N_WAY-1:0]       slot_valid,
    input  icache_pkg::line_addr_t [N_PREFETCH-1:0]  pf_line,
    input  logic                   [N_PREFETCH-1:0]  pf_valid,
    input  logic                                     fill_valid,
    input  icache_pkg::line_addr_t                   fill_line,
    input  icache_pkg::line_data_t                   fill_data,
    output logic                   [N_WAY-1:0]       slot_hit,
    output logic                   [N_PREFETCH-1:0]  pf_hit,
    output icache_pkg::inst_t      [N_WAY-1:0]       inst_out,
    output icache_pkg::addr_t      [N_WAY-1:0]       addr_out,
    output logic                   [N_WAY-1:0]       valid_out,
    output logic [$clog2(N_WAY):0]                   hit_count
);

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int LA_W  = icache_pkg::LINE_ADDR_W;
    localparam int TAG_W = LA_W - IDX_W;

    // Direct mapped storage
    icache_pkg::line_data_t data_mem [CACHE_LINES];
    logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
    logic [CACHE_LINES-1:0] line_valid;

    icache_pkg::line_addr_t [N_WAY-1:0] slot_line;
    icache_pkg::line_data_t [N_WAY-1:0] slot_data;
    logic [N_WAY-1:0]                   lead_mask;
    logic [$clog2(N_WAY):0]             lead_count;
    logic                               run;

    // Tag compare for every fetch slot
    always_comb begin
        for (int i = 0; i < N_WAY; i++) begin
            slot_line[i] = slot_addr[i][icache_pkg::ADDR_W-1:3];
            slot_data[i] = data_mem[slot_line[i][IDX_W-1:0]];
            slot_hit[i]  = slot_valid[i]
                        && line_valid[slot_line[i][IDX_W-1:0]]
                        && (tag_mem[slot_line[i][IDX_W-1:0]] == slot_line[i][LA_W-1:IDX_W]);
        end
    end

    // Same compare for prefetch lines
    always_comb begin
        for (int j = 0; j < N_PREFETCH; j++) begin
            pf_hit[j] = pf_valid[j]
                     && line_valid[pf_line[j][IDX_W-1:0]]
                     && (tag_mem[pf_line[j][IDX_W-1:0]] == pf_line[j][LA_W-1:IDX_W]);
        end
    end

    // Only the unbroken run of hits from slot 0 goes back to fetch
    always_comb begin
        run        = 1'b1;
        lead_count = '0;
        for (int i = 0; i < N_WAY; i++) begin
            run          = run & slot_hit[i];
            lead_mask[i] = run;
            if (run) begin
                lead_count = lead_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            valid_out  <= '0;
            hit_count  <= '0;
        end else begin
            if (fill_valid) begin
                line_valid[fill_line[IDX_W-1:0]] <= 1'b1;
            end
            valid_out <= lead_mask;
            hit_count <= lead_count;
        end
    end

    // Fill overwrites whatever line sat at that index
    always_ff @(posedge clock) begin
        if (fill_valid) begin
            data_mem[fill_line[IDX_W-1:0]] <= fill_data;
            tag_mem[fill_line[IDX_W-1:0]]  <= fill_line[LA_W-1:IDX_W];
        end
        for (int i = 0; i < N_WAY; i++) begin
            // Address bit 2 picks the upper word of the line
            inst_out[i] <= slot_addr[i][2] ? slot_data[i][63:32] : slot_data[i][31:0];
            addr_out[i] <= slot_addr[i];
        end
    end

endmodule

`default_nettype wire

//--- verilog/miss_queue.sv
`default_nettype none

module miss_queue #(
    parameter int N_WAY       = 2,
    parameter int N_PREFETCH  = 2,
    parameter int MISS_Q_SIZE = 8
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     enable,
    input  icache_pkg::addr_t      [N_WAY-1:0]       slot_addr,
    input  logic                   [N_WAY-1:0]       slot_valid,
    input  logic                   [N_WAY-1:0]       slot_hit,
    input  icache_pkg::line_addr_t [N_PREFETCH-1:0]  pf_line,
    input  logic                   [N_PREFETCH-1:0]  pf_valid,
    input  logic                   [N_PREFETCH-1:0]  pf_hit,
    input  logic                                     tracker_full,
    input  logic                                     fill_valid,
    input  icache_pkg::line_addr_t                   fill_line,
    input  icache_pkg::mem_tag_t                     mem_response,
    output icache_pkg::mem_command_t                 mem_command,
    output icache_pkg::addr_t                        mem_addr,
    output logic                                     issue_accepted,
    output icache_pkg::line_addr_t                   issue_line
);

    localparam int N_CAND = N_WAY + N_PREFETCH;
    // Power of two depth with one wrap bit on each pointer
    localparam int IDX_W = $clog2(MISS_Q_SIZE);
    localparam logic [IDX_W:0] DEPTH = (IDX_W + 1)'(MISS_Q_SIZE);

    icache_pkg::line_addr_t q_line [MISS_Q_SIZE];
    logic [MISS_Q_SIZE-1:0] q_pend;
    logic [IDX_W:0]         head;
    logic [IDX_W:0]         issue_ptr;
    logic [IDX_W:0]         tail;
    logic [IDX_W:0]         used;

    icache_pkg::line_addr_t [N_CAND-1:0] cand_line;
    logic [N_CAND-1:0]                   cand_req;
    logic [N_CAND-1:0]                   cand_enq;
    logic [IDX_W:0]                      cand_pos [N_CAND];
    logic [IDX_W:0]                      enq_count;
    logic                                dup;

    logic           retire;
    logic           retry;
    logic           load_next;
    logic [IDX_W:0] issue_next;

    assign used = tail - head;

    // Candidates in slot order, then prefetch order
    always_comb begin
        for (int i = 0; i < N_WAY; i++) begin
            cand_line[i] = slot_addr[i][icache_pkg::ADDR_W-1:3];
            cand_req[i]  = slot_valid[i] & ~slot_hit[i];
        end
        for (int j = 0; j < N_PREFETCH; j++) begin
            cand_line[N_WAY+j] = pf_line[j];
            cand_req[N_WAY+j]  = pf_valid[j] & ~pf_hit[j];
        end
    end

    // Duplicate filter against pending entries and earlier candidates
    always_comb begin
        enq_count = '0;
        for (int c = 0; c < N_CAND; c++) begin
            dup = 1'b0;
            for (int k = 0; k < MISS_Q_SIZE; k++) begin
                if (q_pend[k] && (q_line[k] == cand_line[c])) begin
                    dup = 1'b1;
                end
            end
            for (int e = 0; e < c; e++) begin
                if (cand_req[e] && (cand_line[e] == cand_line[c])) begin
                    dup = 1'b1;
                end
            end
            // Dropped when full and asked for again by fetch
            cand_enq[c] = enable && cand_req[c] && !dup && ((used + enq_count) < DEPTH);
            cand_pos[c] = tail + enq_count;
            if (cand_enq[c]) begin
                enq_count = enq_count + 1'b1;
            end
        end
    end

    // Fills come back in issue order and match the head
    assign retire = fill_valid && q_pend[head[IDX_W-1:0]] && (q_line[head[IDX_W-1:0]] == fill_line);

    assign issue_accepted = (mem_command == icache_pkg::BUS_LOAD) && (mem_response != '0);
    assign issue_line     = mem_addr[icache_pkg::ADDR_W-1:3];
    assign retry          = (mem_command == icache_pkg::BUS_LOAD) && !issue_accepted;
    assign issue_next     = issue_ptr + {{IDX_W{1'b0}}, issue_accepted};
    assign load_next      = !retry && (issue_next != tail) && !tracker_full;

    always_ff @(posedge clock) begin
        if (reset) begin
            head        <= '0;
            issue_ptr   <= '0;
            tail        <= '0;
            q_pend      <= '0;
            mem_command <= icache_pkg::BUS_NONE;
        end else begin
            for (int c = 0; c < N_CAND; c++) begin
                if (cand_enq[c]) begin
                    q_pend[cand_pos[c][IDX_W-1:0]] <= 1'b1;
                end
            end
            if (retire) begin
                q_pend[head[IDX_W-1:0]] <= 1'b0;
            end
            head      <= head + {{IDX_W{1'b0}}, retire};
            tail      <= tail + enq_count;
            issue_ptr <= issue_next;
            // A rejected load stays on the bus unchanged
            mem_command <= (retry || load_next) ? icache_pkg::BUS_LOAD : icache_pkg::BUS_NONE;
        end
    end

    always_ff @(posedge clock) begin
        for (int c = 0; c < N_CAND; c++) begin
            if (cand_enq[c]) begin
                q_line[cand_pos[c][IDX_W-1:0]] <= cand_line[c];
            end
        end
        if (load_next) begin
            mem_addr <= {q_line[issue_next[IDX_W-1:0]], 3'b000};
        end
    end

endmodule

`default_nettype wire

//--- verilog/response_tracker.sv
`default_nettype none

module response_tracker #(
    parameter int TRACK_Q_SIZE = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   issue_accepted,
    input  icache_pkg::line_addr_t issue_line,
    input  icache_pkg::mem_tag_t   mem_response,
    input  icache_pkg::mem_tag_t   mem_tag,
    input  icache_pkg::line_data_t mem_data,
    output logic                   tracker_full,
    output logic                   fill_valid,
    output icache_pkg::line_addr_t fill_line,
    output icache_pkg::line_data_t fill_data
);

    localparam int IDX_W = $clog2(TRACK_Q_SIZE);
    localparam logic [IDX_W:0] DEPTH = (IDX_W + 1)'(TRACK_Q_SIZE);

    // Outstanding loads with the tag memory gave them
    icache_pkg::line_addr_t trk_line [TRACK_Q_SIZE];
    icache_pkg::mem_tag_t   trk_tag  [TRACK_Q_SIZE];
    logic [IDX_W:0]         head;
    logic [IDX_W:0]         tail;
    logic [IDX_W:0]         used;
    logic                   pop;

    assign used = tail - head;

    // Memory answers in order so only the head can match
    assign pop = (used != '0) && (mem_tag != '0) && (mem_tag == trk_tag[head[IDX_W-1:0]]);

    assign fill_valid = pop;
    assign fill_line  = trk_line[head[IDX_W-1:0]];
    assign fill_data  = mem_data;

    // Counts a load accepted this cycle so the next one cannot overrun
    assign tracker_full = (used + {{IDX_W{1'b0}}, issue_accepted}) >= DEPTH;

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= head + {{IDX_W{1'b0}}, pop};
            tail <= tail + {{IDX_W{1'b0}}, issue_accepted};
        end
    end

    always_ff @(posedge clock) begin
        if (issue_accepted) begin
            trk_line[tail[IDX_W-1:0]] <= issue_line;
            trk_tag[tail[IDX_W-1:0]]  <= mem_response;
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
`default_nettype none

module icache_top #(
    parameter int N_WAY        = 2,
    parameter int CACHE_LINES  = 32,
    parameter int N_PREFETCH   = 2,
    parameter int MISS_Q_SIZE  = 8,
    parameter int TRACK_Q_SIZE = 4
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               enable,
    input  icache_pkg::addr_t                  fetch_addr,
    input  logic [$clog2(N_WAY):0]             fetch_count,
    input  icache_pkg::mem_tag_t               mem_response,
    input  icache_pkg::line_data_t             mem_data,
    input  icache_pkg::mem_tag_t               mem_tag,
    output icache_pkg::mem_command_t           mem_command,
    output icache_pkg::addr_t                  mem_addr,
    output icache_pkg::inst_t [N_WAY-1:0]      inst_out,
    output icache_pkg::addr_t [N_WAY-1:0]      addr_out,
    output logic              [N_WAY-1:0]      valid_out,
    output logic [$clog2(N_WAY):0]             hit_count
);

    icache_pkg::addr_t      [N_WAY-1:0]      slot_addr;
    logic                   [N_WAY-1:0]      slot_valid;
    logic                   [N_WAY-1:0]      slot_hit;
    icache_pkg::line_addr_t [N_PREFETCH-1:0] pf_line;
    logic                   [N_PREFETCH-1:0] pf_valid;
    logic                   [N_PREFETCH-1:0] pf_hit;

    logic                   tracker_full;
    logic                   fill_valid;
    icache_pkg::line_addr_t fill_line;
    icache_pkg::line_data_t fill_data;
    logic                   issue_accepted;
    icache_pkg::line_addr_t issue_line;

    fetch_request_gen #(
        .N_WAY      (N_WAY),
        .N_PREFETCH (N_PREFETCH)
    ) u_fetch_request_gen (
        .enable      (enable),
        .fetch_addr  (fetch_addr),
        .fetch_count (fetch_count),
        .slot_addr   (slot_addr),
        .slot_valid  (slot_valid),
        .pf_line     (pf_line),
        .pf_valid    (pf_valid)
    );

    icache_array #(
        .N_WAY       (N_WAY),
        .N_PREFETCH  (N_PREFETCH),
        .CACHE_LINES (CACHE_LINES)
    ) u_icache_array (
        .clock      (clock),
        .reset      (reset),
        .slot_addr  (slot_addr),
        .slot_valid (slot_valid),
        .pf_line    (pf_line),
        .pf_valid   (pf_valid),
        .fill_valid (fill_valid),
        .fill_line  (fill_line),
        .fill_data  (fill_data),
        .slot_hit   (slot_hit),
        .pf_hit     (pf_hit),
        .inst_out   (inst_out),
        .addr_out   (addr_out),
        .valid_out  (valid_out),
        .hit_count  (hit_count)
    );

    miss_queue #(
        .N_WAY       (N_WAY),
        .N_PREFETCH  (N_PREFETCH),
        .MISS_Q_SIZE (MISS_Q_SIZE)
    ) u_miss_queue (
        .clock          (clock),
        .reset          (reset),
        .enable         (enable),
        .slot_addr      (slot_addr),
        .slot_valid     (slot_valid),
        .slot_hit       (slot_hit),
        .pf_line        (pf_line),
        .pf_valid       (pf_valid),
        .pf_hit         (pf_hit),
        .tracker_full   (tracker_full),
        .fill_valid     (fill_valid),
        .fill_line      (fill_line),
        .mem_response   (mem_response),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .issue_accepted (issue_accepted),
        .issue_line     (issue_line)
    );

    response_tracker #(
        .TRACK_Q_SIZE (TRACK_Q_SIZE)
    ) u_response_tracker (
        .clock          (clock),
        .reset          (reset),
        .issue_accepted (issue_accepted),
        .issue_line     (issue_line),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .mem_data       (mem_data),
        .tracker_full   (tracker_full),
        .fill_valid     (fill_valid),
        .fill_line      (fill_line),
        .fill_data      (fill_data)
    );

endmodule

`default_nettype wire

//--- test/mem_model.sv
`default_nettype none

module mem_model #(
    parameter int LATENCY = 6
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     force_reject,
    input  icache_pkg::mem_command_t mem_command,
    input  icache_pkg::addr_t        mem_addr,
    output icache_pkg::mem_tag_t     mem_response,
    output icache_pkg::line_data_t   mem_data,
    output icache_pkg::mem_tag_t     mem_tag,
    output int                       load_count
);

    localparam icache_pkg::inst_t WORD_KEY = 32'h5a5a0000;

    logic                 reject;
    logic                 accept;
    icache_pkg::mem_tag_t next_tag;
    logic [LATENCY-1:0]   pipe_valid;
    icache_pkg::addr_t    pipe_addr [LATENCY];
    icache_pkg::mem_tag_t pipe_tag  [LATENCY];

    // Tag is granted in the same cycle as the command
    assign accept       = (mem_command == icache_pkg::BUS_LOAD) && !reject;
    assign mem_response = accept ? next_tag : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            reject     <= 1'b0;
            next_tag   <= 4'd1;
            pipe_valid <= '0;
            mem_tag    <= '0;
            load_count <= 0;
        end else begin
            // Roughly one load in four is turned away
            reject     <= force_reject || (($urandom % 4) == 0);
            pipe_valid <= {pipe_valid[LATENCY-2:0], accept};
            mem_tag    <= pipe_valid[LATENCY-1] ? pipe_tag[LATENCY-1] : '0;
            if (accept) begin
                next_tag   <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                load_count <= load_count + 1;
            end
        end
    end

    // Data travels in order next to its tag
    always_ff @(posedge clock) begin
        pipe_addr[0] <= mem_addr;
        pipe_tag[0]  <= next_tag;
        for (int k = 1; k < LATENCY; k++) begin
            pipe_addr[k] <= pipe_addr[k-1];
            pipe_tag[k]  <= pipe_tag[k-1];
        end
        mem_data <= {(pipe_addr[LATENCY-1] + 32'd4) ^ WORD_KEY,
                     pipe_addr[LATENCY-1] ^ WORD_KEY};
    end

endmodule

`default_nettype wire

//--- test/icache_sva.sv
`default_nettype none

module icache_sva #(
    parameter int N_WAY = 2
) (
    input logic                     clock,
    input logic                     reset,
    input icache_pkg::mem_command_t mem_command,
    input icache_pkg::addr_t        mem_addr,
    input logic [N_WAY-1:0]         valid_out
);

    logic [N_WAY-1:0] valid_plus;

    // A run of ones from bit 0 turns to zero when one is added
    assign valid_plus = valid_out + 1'b1;

    load_aligned: assert property (@(posedge clock) disable iff (reset)
        (mem_command == icache_pkg::BUS_LOAD) |-> (mem_addr[2:0] == 3'b000))
        else $error("load address %h is not line aligned", mem_addr);

    reset_idle: assert property (@(posedge clock)
        reset |=> ((valid_out == '0) && (mem_command == icache_pkg::BUS_NONE)))
        else $error("outputs are not idle after reset");

    valid_leading: assert property (@(posedge clock) disable iff (reset)
        ((valid_plus & valid_out) == '0))
        else $error("valid_out %b has a set bit above a clear bit", valid_out);

endmodule

`default_nettype wire

//--- test/icache_tb.sv
`default_nettype none

module icache_tb;

    localparam int N_WAY   = 2;
    localparam int TIMEOUT = 200;

    typedef logic [$clog2(N_WAY):0] count_t;
    typedef logic [N_WAY-1:0]       valid_t;

    logic                          clock;
    logic                          reset;
    logic                          enable;
    logic                          force_reject;
    icache_pkg::addr_t             fetch_addr;
    count_t                        fetch_count;
    icache_pkg::mem_tag_t          mem_response;
    icache_pkg::line_data_t        mem_data;
    icache_pkg::mem_tag_t          mem_tag;
    icache_pkg::mem_command_t      mem_command;
    icache_pkg::addr_t             mem_addr;
    icache_pkg::inst_t [N_WAY-1:0] inst_out;
    icache_pkg::addr_t [N_WAY-1:0] addr_out;
    valid_t                        valid_out;
    count_t                        hit_count;
    int                            load_count;

    int                     errors;
    int                     checks;
    icache_pkg::line_addr_t loaded_lines [$];

    icache_top #(
        .N_WAY (N_WAY)
    ) u_icache_top (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .fetch_addr   (fetch_addr),
        .fetch_count  (fetch_count),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .inst_out     (inst_out),
        .addr_out     (addr_out),
        .valid_out    (valid_out),
        .hit_count    (hit_count)
    );

    mem_model u_mem_model (
        .clock        (clock),
        .reset        (reset),
        .force_reject (force_reject),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag),
        .load_count   (load_count)
    );

    bind icache_top icache_sva #(.N_WAY(N_WAY)) u_icache_sva (
        .clock       (clock),
        .reset       (reset),
        .mem_command (mem_command),
        .mem_addr    (mem_addr),
        .valid_out   (valid_out)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Log of every load that memory accepted
    always @(posedge clock) begin
        if (!reset && mem_command == icache_pkg::BUS_LOAD && mem_response != '0) begin
            loaded_lines.push_back(mem_addr[31:3]);
        end
    end

    // Word at byte address a is a XOR 5a5a0000
    function automatic icache_pkg::inst_t expected_word(input icache_pkg::addr_t addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    function automatic int count_loads(input icache_pkg::line_addr_t line);
        int n;
        n = 0;
        foreach (loaded_lines[k]) begin
            if (loaded_lines[k] == line) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int count_reloads();
        int n;
        n = 0;
        foreach (loaded_lines[k]) begin
            if (count_loads(loaded_lines[k]) > 1) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_inst(input string name, input icache_pkg::inst_t expected,
                              input icache_pkg::inst_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::addr_t expected,
                              input icache_pkg::addr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input count_t expected,
                               input count_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_valid(input string name, input valid_t expected,
                               input valid_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_command(input string name, input icache_pkg::mem_command_t expected,
                                 input icache_pkg::mem_command_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_loads(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("Fail %s: expected %0d loads, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_slots(input string name, input icache_pkg::addr_t addr,
                               input int count);
        for (int i = 0; i < count; i++) begin
            check_inst(name, expected_word(addr + icache_pkg::addr_t'(4 * i)), inst_out[i]);
            check_addr(name, addr + icache_pkg::addr_t'(4 * i), addr_out[i]);
        end
    endtask

    // Holds the fetch on the inputs until every requested slot hits
    task automatic fetch_until_hit(input string name, input icache_pkg::addr_t addr,
                                   input count_t count);
        int cycles;
        cycles      = 0;
        enable      = 1'b1;
        fetch_addr  = addr;
        fetch_count = count;
        @(negedge clock);
        while (hit_count != count && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (hit_count != count) begin
            errors++;
            $display("%s: fetch at %h did not hit within %0d cycles", name, addr, TIMEOUT);
        end
    endtask

    // Waits until memory has accepted a load of the line
    task automatic wait_for_load(input string name, input icache_pkg::line_addr_t line);
        int cycles;
        cycles = 0;
        while (count_loads(line) == 0 && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (count_loads(line) == 0) begin
            errors++;
            $display("%s: line %h was not loaded within %0d cycles", name, line, TIMEOUT);
        end
    endtask

    task automatic go_idle();
        enable      = 1'b0;
        fetch_count = '0;
        @(negedge clock);
    endtask

    task automatic reset_state();
        check_valid("reset_state", '0, valid_out);
        check_count("reset_state", '0, hit_count);
        check_command("reset_state", icache_pkg::BUS_NONE, mem_command);
    endtask

    task automatic cold_miss_fill();
        fetch_until_hit("cold_miss_fill", 32'h100, count_t'(2));
        check_valid("cold_miss_fill", '1, valid_out);
        check_slots("cold_miss_fill", 32'h100, 2);
        go_idle();
    endtask

    task automatic partial_count();
        enable      = 1'b1;
        fetch_addr  = 32'h100;
        fetch_count = count_t'(1);
        @(negedge clock);
        check_valid("partial_count", valid_t'(1), valid_out);
        check_count("partial_count", count_t'(1), hit_count);
        check_slots("partial_count", 32'h100, 1);
        // An empty request returns nothing
        fetch_count = '0;
        @(negedge clock);
        check_valid("partial_count", '0, valid_out);
        check_count("partial_count", '0, hit_count);
        go_idle();
    endtask

    task automatic line_straddle();
        fetch_until_hit("line_straddle", 32'h204, count_t'(2));
        check_valid("line_straddle", '1, valid_out);
        check_slots("line_straddle", 32'h204, 2);
        go_idle();
    endtask

    task automatic prefetch_lines();
        int mark;
        fetch_until_hit("prefetch_lines", 32'h300, count_t'(2));
        check_slots("prefetch_lines", 32'h300, 2);
        // The two lines after 0x300 are requested before any demand for them
        wait_for_load("prefetch_lines", 29'h61);
        wait_for_load("prefetch_lines", 29'h62);
        mark = load_count;
        fetch_until_hit("prefetch_lines", 32'h308, count_t'(2));
        check_slots("prefetch_lines", 32'h308, 2);
        fetch_until_hit("prefetch_lines", 32'h310, count_t'(2));
        check_slots("prefetch_lines", 32'h310, 2);
        // Only the new prefetch lines 0x63 and 0x64 cost a load
        wait_for_load("prefetch_lines", 29'h64);
        check_loads("prefetch_lines", mark + 2, load_count);
        check_loads("prefetch_lines", 1, count_loads(29'h61));
        check_loads("prefetch_lines", 1, count_loads(29'h62));
        go_idle();
    endtask

    task automatic reject_retry();
        force_reject = 1'b1;
        enable       = 1'b1;
        fetch_addr   = 32'h400;
        fetch_count  = count_t'(2);
        repeat (20) @(negedge clock);
        // The rejected load is still offered to memory
        check_command("reject_retry", icache_pkg::BUS_LOAD, mem_command);
        force_reject = 1'b0;
        fetch_until_hit("reject_retry", 32'h400, count_t'(2));
        check_slots("reject_retry", 32'h400, 2);
        check_loads("reject_retry", 1, count_loads(29'h80));
        check_loads("reject_retry", 0, count_reloads());
        go_idle();
    endtask

    initial begin
        void'($urandom(32'h166b));
        errors       = 0;
        checks       = 0;
        reset        = 1'b1;
        enable       = 1'b0;
        force_reject = 1'b0;
        fetch_addr   = '0;
        fetch_count  = '0;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        reset_state();
        cold_miss_fill();
        partial_count();
        line_straddle();
        prefetch_lines();
        reject_retry();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_top.f
verilog/icache_pkg.sv
verilog/fetch_request_gen.sv
verilog/icache_array.sv
verilog/miss_queue.sv
verilog/response_tracker.sv
verilog/icache_top.sv
test/mem_model.sv
test/icache_sva.sv
test/icache_tb.sv

//--- run.sh
#!/bin/sh
# Builds the icache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -f icache_top.f -o icache_sim

out=$(./obj_dir/icache_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Test OK$'; then
    exit 0
fi
exit 1
